// ==== icache.f ====
logic/icache_pkg.sv
logic/icache_predecode.sv
logic/icache_mem.sv
logic/icache_target.sv
logic/icache_top.sv
tb/icache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the icache testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f icache.f --top-module icache_tb -o icache_sim > build.log 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
  cat build.log
  echo "build failed with status $build_status"
  exit 1
fi

./obj_dir/icache_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "TEST RESULT: PASS" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== tb/icache_tb.sv ====
// icache testbench
// fills the cache with plain words, branches and jal, reads them back, and
// checks each fetch one cycle later with concurrent assertions
`timescale 1ns/1ps

module icache_tb;
  import icache_pkg::*;

  localparam int num_tests_lp   = 5;
  localparam int clk_period_lp  = 40;
  localparam int entries_lp     = 1 << icache_addr_width_lp;
  localparam int kind_plain_lp  = 0;
  localparam int kind_branch_lp = 1;
  localparam int kind_jal_lp    = 2;

  logic clk_i, reset_i, icache_cen_i, icache_w_en_i, pc_wen_i, icache_miss_o;
  logic [icache_addr_width_lp-1:0] icache_w_addr_i;
  logic [icache_tag_width_lp-1:0]  icache_w_tag_i;
  logic [instr_width_lp-1:0]       icache_w_instr_i, instruction_o, exp_instr, prev_instr;
  logic [pc_width_lp-1:0]          pc_i, pc_r_o, jump_addr_o, exp_pc, exp_jump, prev_pc, prev_jump;
  logic                            exp_miss, chk_instr, chk_jump, read_launch;

  // shadow of every written word, with the original immediate
  logic [instr_width_lp-1:0]      shadow_instr [entries_lp];
  logic [icache_tag_width_lp-1:0] shadow_tag   [entries_lp];
  int                             shadow_imm   [entries_lp];
  int                             shadow_kind  [entries_lp];
  int                             errors;
  int                             tests_failed;

  icache_top icache_top_i (
    .clk_i, .reset_i, .icache_cen_i, .icache_w_en_i, .icache_w_addr_i, .icache_w_tag_i,
    .icache_w_instr_i, .pc_i, .pc_wen_i, .instruction_o, .pc_r_o, .jump_addr_o, .icache_miss_o
  );

  always #(clk_period_lp / 2) clk_i = ~clk_i;

  always @(posedge clk_i) begin
    prev_instr <= instruction_o;
    prev_jump  <= jump_addr_o;
    prev_pc    <= pc_r_o;
  end

  assign read_launch = icache_cen_i && !icache_w_en_i && pc_wen_i;

  function automatic void report_mismatch(string sig, logic [31:0] got, logic [31:0] exp);
    errors++;
    $display("FAIL %0t %s got %h expected %h", $time, sig, got, exp);
  endfunction

  // --------------------
  // checks
  // --------------------
  reset_pc_a: assert property (@(posedge clk_i) $fell(reset_i) |-> pc_r_o == '0)
    else report_mismatch("pc_r_o", 32'($sampled(pc_r_o)), 32'd0);
  reset_miss_a: assert property (@(posedge clk_i) $fell(reset_i) |-> !icache_miss_o)
    else report_mismatch("icache_miss_o", 32'($sampled(icache_miss_o)), 32'd0);
  pc_load_a: assert property (@(posedge clk_i) disable iff (reset_i)
    read_launch |=> pc_r_o == exp_pc)
    else report_mismatch("pc_r_o", 32'($sampled(pc_r_o)), 32'($sampled(exp_pc)));
  instr_a: assert property (@(posedge clk_i) disable iff (reset_i)
    read_launch && chk_instr |=> instruction_o == exp_instr)
    else report_mismatch("instruction_o", $sampled(instruction_o), $sampled(exp_instr));
  jump_a: assert property (@(posedge clk_i) disable iff (reset_i)
    read_launch && chk_jump |=> jump_addr_o == exp_jump)
    else report_mismatch("jump_addr_o", 32'($sampled(jump_addr_o)), 32'($sampled(exp_jump)));
  miss_a: assert property (@(posedge clk_i) disable iff (reset_i)
    read_launch |=> icache_miss_o == exp_miss)
    else report_mismatch("icache_miss_o", 32'($sampled(icache_miss_o)), 32'($sampled(exp_miss)));
  // no pc load, no change at the outputs
  hold_instr_a: assert property (@(posedge clk_i) disable iff (reset_i)
    !pc_wen_i |=> instruction_o == prev_instr)
    else report_mismatch("instruction_o", $sampled(instruction_o), $sampled(prev_instr));
  hold_jump_a: assert property (@(posedge clk_i) disable iff (reset_i)
    !pc_wen_i |=> jump_addr_o == prev_jump)
    else report_mismatch("jump_addr_o", 32'($sampled(jump_addr_o)), 32'($sampled(prev_jump)));
  hold_pc_a: assert property (@(posedge clk_i) disable iff (reset_i)
    !pc_wen_i |=> pc_r_o == prev_pc)
    else report_mismatch("pc_r_o", 32'($sampled(pc_r_o)), 32'($sampled(prev_pc)));

  // --------------------
  // stimulus helpers
  // --------------------
  function automatic logic [31:0] plain_word(logic [31:0] raw);
    if (raw[6:0] == opcode_branch_lp || raw[6:0] == opcode_jal_lp) begin
      raw[6:0] = 7'b0010011;
    end
    return raw;
  endfunction

  // word aligned byte offset, 13 bits for branch, 21 for jal
  function automatic int random_imm(int kind);
    logic signed [12:0] b;
    logic signed [20:0] j;
    b = 13'($urandom) & 13'h1ffc;
    j = 21'($urandom) & 21'h1ffffc;
    return (kind == kind_branch_lp) ? int'(b) : int'(j);
  endfunction

  function automatic logic [31:0] encode_jump(int kind, int imm, logic [31:0] fill);
    logic [20:0] u;
    u = imm[20:0];
    if (kind == kind_branch_lp) begin
      return {u[12], u[10:5], fill[24:12], u[4:1], u[11], opcode_branch_lp};
    end
    return {u[20], u[10:1], u[11], u[19:12], fill[11:7], opcode_jal_lp};
  endfunction

  task automatic idle(int cycles);
    repeat (cycles) begin
      @(posedge clk_i);
      icache_w_en_i <= 1'b0;
      pc_wen_i      <= 1'b0;
    end
  endtask

  task automatic write_word(logic [7:0] idx, logic [11:0] tag, logic [31:0] instr,
                            int kind, int imm);
    @(posedge clk_i);
    icache_cen_i      <= 1'b1;
    icache_w_en_i     <= 1'b1;
    icache_w_addr_i   <= idx;
    icache_w_tag_i    <= tag;
    icache_w_instr_i  <= instr;
    pc_wen_i          <= 1'b0;
    shadow_instr[idx] = instr;
    shadow_tag[idx]   = tag;
    shadow_kind[idx]  = kind;
    shadow_imm[idx]   = imm;
  endtask

  // launch, drop pc_wen, then the edge where the assertions look
  task automatic read_pc(logic [pc_width_lp-1:0] pc);
    logic [icache_addr_width_lp-1:0] idx;
    logic                            miss;
    int                              target;
    idx    = pc[icache_addr_width_lp-1:0];
    miss   = (shadow_tag[idx] != pc[pc_width_lp-1:icache_addr_width_lp]);
    target = int'(pc) + (shadow_imm[idx] >>> 2);
    @(posedge clk_i);
    icache_cen_i  <= 1'b1;
    icache_w_en_i <= 1'b0;
    pc_i          <= pc;
    pc_wen_i      <= 1'b1;
    exp_pc        <= pc;
    exp_instr     <= shadow_instr[idx];
    exp_jump      <= target[pc_width_lp-1:0];
    exp_miss      <= miss;
    chk_instr     <= (shadow_kind[idx] == kind_plain_lp);
    chk_jump      <= (shadow_kind[idx] != kind_plain_lp) && !miss;
    @(posedge clk_i);
    pc_wen_i <= 1'b0;
    @(posedge clk_i);
  endtask

  task automatic jump_case(int kind, logic [7:0] idx, logic [11:0] tag, int imm);
    write_word(idx, tag, encode_jump(kind, imm, $urandom), kind, imm);
    read_pc({tag, idx});
  endtask

  task automatic finish_test(int num, string name, int errs_before);
    idle(2);
    if (errors == errs_before) begin
      $display("test %0d %s: passed", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", num, name, errors - errs_before);
    end
  endtask

  // --------------------
  // tests
  // --------------------
  task automatic plain_readback();
    int         errs_before;
    logic [7:0] idx;
    errs_before = errors;
    for (int i = 0; i < entries_lp; i++) begin
      write_word(8'(i), 12'($urandom), plain_word($urandom), kind_plain_lp, 0);
    end
    repeat (24) begin
      idx = 8'($urandom);
      read_pc({shadow_tag[idx], idx});
    end
    finish_test(1, "reset and plain words", errs_before);
  endtask

  task automatic jump_targets(int num, int kind, string name);
    int errs_before;
    errs_before = errors;
    // carry and borrow across the low part, and a wrap of the word pc
    if (kind == kind_branch_lp) begin
      jump_case(kind, 8'hff, 12'h3a7, 4);
      jump_case(kind, 8'h00, 12'h3a8, -4);
      jump_case(kind, 8'h80, 12'h001, -4096);
    end else begin
      jump_case(kind, 8'hff, 12'h7ff, 4);
      jump_case(kind, 8'h00, 12'h800, -4);
      jump_case(kind, 8'hff, 12'hfff, 8);
    end
    repeat (20) jump_case(kind, 8'($urandom), 12'($urandom), random_imm(kind));
    finish_test(num, name, errs_before);
  endtask

  task automatic tag_miss();
    int         errs_before;
    logic [7:0] idx;
    errs_before = errors;
    repeat (8) begin
      idx = 8'($urandom);
      read_pc({shadow_tag[idx] ^ (12'($urandom) | 12'h001), idx});
      read_pc({shadow_tag[idx], idx});
    end
    finish_test(4, "tag miss", errs_before);
  endtask

  task automatic stall_hold();
    int         errs_before;
    logic [7:0] idx;
    errs_before = errors;
    repeat (6) begin
      idx = 8'($urandom);
      read_pc({shadow_tag[idx], idx});
      repeat (3 + $urandom % 6) begin
        if ($urandom % 2) begin
          write_word(idx, 12'($urandom), plain_word($urandom), kind_plain_lp, 0);
        end else begin
          @(posedge clk_i);
          icache_w_en_i <= 1'b0;
          icache_cen_i  <= 1'($urandom);
          pc_i          <= 20'($urandom);
          pc_wen_i      <= 1'b0;
        end
      end
      idle(1);
    end
    finish_test(5, "stall hold", errs_before);
  endtask

  initial begin
    repeat (num_tests_lp * 300) #(clk_period_lp);
    $display("watchdog expired, the tests did not finish in time");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    clk_i = 1'b0;
    reset_i = 1'b1;
    icache_cen_i = 1'b0;
    icache_w_en_i = 1'b0;
    icache_w_addr_i = '0;
    icache_w_tag_i = '0;
    icache_w_instr_i = '0;
    pc_i = '0;
    pc_wen_i = 1'b0;
    {exp_instr, exp_pc, exp_jump, exp_miss, chk_instr, chk_jump} = '0;
    errors = 0;
    tests_failed = 0;
    void'($urandom(32'hf3b911de));
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;
    plain_readback();
    jump_targets(2, kind_branch_lp, "branch targets");
    jump_targets(3, kind_jal_lp, "jal targets");
    tag_miss();
    stall_hold();
    $display("tests run %0d, failed %0d, errors %0d", num_tests_lp, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== logic/icache_top.sv ====
// icache top
// fill port with pre-decode, one-cycle fetch from a registered pc, output
// held while no new pc is loaded, and a tag compare for the miss flag
`timescale 1ns/1ps

module icache_top (
  input                                          clk_i,
  input                                          reset_i,

  // fill
  input                                          icache_cen_i,
  input                                          icache_w_en_i,
  input        [icache_pkg::icache_addr_width_lp-1:0] icache_w_addr_i,
  input        [icache_pkg::icache_tag_width_lp-1:0]  icache_w_tag_i,
  input        [icache_pkg::instr_width_lp-1:0]       icache_w_instr_i,

  // fetch
  input        [icache_pkg::pc_width_lp-1:0]          pc_i,
  input                                          pc_wen_i,

  // results
  output logic [icache_pkg::instr_width_lp-1:0]       instruction_o,
  output logic [icache_pkg::pc_width_lp-1:0]          pc_r_o,
  output logic [icache_pkg::pc_width_lp-1:0]          jump_addr_o,
  output logic                                   icache_miss_o
);
  import icache_pkg::*;

  icache_entry_s                   w_entry;
  icache_entry_s                   r_entry;
  icache_entry_s                   held_entry;
  icache_entry_s                   cur_entry;
  logic [icache_addr_width_lp-1:0] mem_addr;
  logic [pc_width_lp-1:0]          pc_r;
  logic                            pc_wen_r;

  // --------------------
  // fill path
  // --------------------
  icache_predecode icache_predecode_i (
    .w_addr_i  (icache_w_addr_i),
    .w_tag_i   (icache_w_tag_i),
    .w_instr_i (icache_w_instr_i),
    .w_entry_o (w_entry)
  );

  // write owns the port, otherwise the next pc index
  assign mem_addr = icache_w_en_i ? icache_w_addr_i : pc_i[icache_addr_width_lp-1:0];

  icache_mem #(
    .entry_t (icache_entry_s)
  ) icache_mem_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     (icache_cen_i),
    .w_i     (icache_w_en_i),
    .addr_i  (mem_addr),
    .data_i  (w_entry),
    .data_o  (r_entry)
  );

  // --------------------
  // fetch pc and hold
  // --------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_wen_r <= 1'b0;
    end else begin
      pc_wen_r <= pc_wen_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_r <= '0;
    end else if (pc_wen_i) begin
      pc_r <= pc_i;
    end
  end

  // re-captured every cycle so a stall keeps the last fetched entry
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      held_entry <= '0;
    end else begin
      held_entry <= cur_entry;
    end
  end

  assign cur_entry = pc_wen_r ? r_entry : held_entry;

  icache_target icache_target_i (
    .pc_r_i      (pc_r),
    .entry_i     (cur_entry),
    .jump_addr_o (jump_addr_o)
  );

  assign instruction_o = cur_entry.instr;
  assign pc_r_o        = pc_r;
  assign icache_miss_o = (cur_entry.tag != pc_r[pc_width_lp-1:icache_addr_width_lp]);

  // a pc load in a write cycle would latch a stale read
  no_write_on_fetch_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
      (icache_cen_i && icache_w_en_i) |-> !pc_wen_i
  ) else $error("icache_top: write issued together with pc_wen_i");

endmodule

// ==== logic/icache_target.sv ====
// icache jump target assembly
// picks the high part of the fetch pc, as is or one up or one down, and
// joins it with the low target stored at write time
`timescale 1ns/1ps

module icache_target (
  input        [icache_pkg::pc_width_lp-1:0] pc_r_i,
  input  icache_pkg::icache_entry_s         entry_i,
  output logic [icache_pkg::pc_width_lp-1:0] jump_addr_o
);
  import icache_pkg::*;

  typedef enum logic [1:0] {
    sel_same,
    sel_plus1,
    sel_minus1
  } target_sel_e;

  logic [pc_width_lp+1:0]          pc_byte;
  logic                            take_plus1;
  logic                            take_minus1;
  target_sel_e                     high_sel;

  logic [branch_high_width_lp-1:0] branch_high;
  logic [branch_high_width_lp-1:0] branch_high_out;
  logic [jal_high_width_lp-1:0]    jal_high;
  logic [jal_high_width_lp-1:0]    jal_high_out;
  logic [pc_width_lp+1:0]          branch_byte;
  logic [pc_width_lp+1:0]          jal_byte;
  logic                            is_jal;

  assign pc_byte     = {pc_r_i, 2'b00};
  assign branch_high = pc_byte[pc_width_lp+1:bimm_low_width_lp];
  assign jal_high    = pc_byte[pc_width_lp+1:jimm_low_width_lp];

  // sign 0 carry 1 steps up, sign 1 carry 0 steps down
  assign take_plus1  = ~entry_i.lower_sign & entry_i.lower_cout;
  assign take_minus1 = entry_i.lower_sign & ~entry_i.lower_cout;

  assign high_sel = take_plus1  ? sel_plus1
                  : take_minus1 ? sel_minus1
                  : sel_same;

  always_comb begin
    case (high_sel)
      sel_plus1: begin
        branch_high_out = branch_high + 1'b1;
        jal_high_out    = jal_high + 1'b1;
      end
      sel_minus1: begin
        branch_high_out = branch_high - 1'b1;
        jal_high_out    = jal_high - 1'b1;
      end
      default: begin
        branch_high_out = branch_high;
        jal_high_out    = jal_high;
      end
    endcase
  end

  // byte targets, the two lsbs are dropped at the output
  assign branch_byte = {branch_high_out, bimm_extract(entry_i.instr)};
  assign jal_byte    = {jal_high_out, jimm_extract(entry_i.instr)};
  assign is_jal      = (entry_i.instr.op == opcode_jal_lp);

  assign jump_addr_o = is_jal ? jal_byte[pc_width_lp+1:2] : branch_byte[pc_width_lp+1:2];

endmodule

// ==== logic/icache_mem.sv ====
// icache storage
// single-port synchronous ram, writes take the port, reads appear one
// cycle later and the read register holds between reads
`timescale 1ns/1ps

module icache_mem #(
  parameter type entry_t = logic
) (
  input                                          clk_i,
  input                                          reset_i,
  input                                          v_i,
  input                                          w_i,
  input        [icache_pkg::icache_addr_width_lp-1:0] addr_i,
  input  entry_t                                 data_i,
  output entry_t                                 data_o
);
  import icache_pkg::*;

  entry_t mem_r [0:(1 << icache_addr_width_lp)-1];
  entry_t data_r;

  always_ff @(posedge clk_i) begin
    if (v_i && w_i) begin
      mem_r[addr_i] <= data_i;
    end
  end

  // read register, only a real read moves it
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      data_r <= '0;
    end else if (v_i && !w_i) begin
      data_r <= mem_r[addr_i];
    end
  end

  assign data_o = data_r;

  addr_known_a: assert property (
    @(posedge clk_i) disable iff (reset_i) v_i |-> !$isunknown(addr_i)
  ) else $error("icache_mem: unknown address with v_i set");

endmodule

// ==== logic/icache_predecode.sv ====
// icache write-side pre-decoder
// adds the branch or jal immediate to the low bits of the write pc and
// stores the sum back in the immediate fields, with sign and carry kept
// alongside so the fetch side only needs an increment or decrement
`timescale 1ns/1ps

module icache_predecode (
  input        [icache_pkg::icache_addr_width_lp-1:0] w_addr_i,
  input        [icache_pkg::icache_tag_width_lp-1:0]  w_tag_i,
  input  icache_pkg::rv32_instr_s                     w_instr_i,
  output icache_pkg::icache_entry_s                   w_entry_o
);
  import icache_pkg::*;

  logic [pc_width_lp+1:0]       w_pc_byte;
  logic                         is_branch;
  logic                         is_jal;

  logic [bimm_low_width_lp-1:0] branch_imm;
  logic [bimm_low_width_lp-1:0] branch_pc_low;
  logic [bimm_low_width_lp-1:0] branch_sum;
  logic                         branch_cout;

  logic [jimm_low_width_lp-1:0] jal_imm;
  logic [jimm_low_width_lp-1:0] jal_pc_low;
  logic [jimm_low_width_lp-1:0] jal_sum;
  logic                         jal_cout;

  rv32_instr_s                  branch_instr;
  rv32_instr_s                  jal_instr;
  logic                         imm_sign;
  logic                         low_cout;

  assign is_branch = (w_instr_i.op == opcode_branch_lp);
  assign is_jal    = (w_instr_i.op == opcode_jal_lp);

  // byte address of the word being written
  assign w_pc_byte = {w_tag_i, w_addr_i, 2'b00};

  // --------------------
  // low target adders
  // --------------------
  assign branch_imm    = bimm_extract(w_instr_i);
  assign branch_pc_low = w_pc_byte[bimm_low_width_lp-1:0];
  assign {branch_cout, branch_sum} = {1'b0, branch_imm} + {1'b0, branch_pc_low};

  assign jal_imm    = jimm_extract(w_instr_i);
  assign jal_pc_low = w_pc_byte[jimm_low_width_lp-1:0];
  assign {jal_cout, jal_sum} = {1'b0, jal_imm} + {1'b0, jal_pc_low};

  // --------------------
  // inject sums, bit 0 dropped
  // --------------------
  always_comb begin
    branch_instr        = w_instr_i;
    branch_instr.funct7 = {branch_sum[12], branch_sum[10:5]};
    branch_instr.rd     = {branch_sum[4:1], branch_sum[11]};
  end

  always_comb begin
    jal_instr        = w_instr_i;
    jal_instr.funct7 = {jal_sum[20], jal_sum[10:5]};
    jal_instr.rs2    = {jal_sum[4:1], jal_sum[11]};
    jal_instr.rs1    = jal_sum[19:15];
    jal_instr.funct3 = jal_sum[14:12];
  end

  // b and j formats both keep the immediate sign in bit 31
  assign imm_sign = w_instr_i.funct7[6];
  // non-jump words take the carry from the jal path, unused later
  assign low_cout = is_branch ? branch_cout : jal_cout;

  assign w_entry_o.lower_sign = imm_sign;
  assign w_entry_o.lower_cout = low_cout;
  assign w_entry_o.tag        = w_tag_i;
  assign w_entry_o.instr      = is_branch ? branch_instr
                              : is_jal    ? jal_instr
                              : w_instr_i;

endmodule

// ==== logic/icache_pkg.sv ====
// icache shared definitions
// address split, rv32 opcode and immediate layout, and the stored
// cache entry with its pre-decoded jump target bits
package icache_pkg;

  // --------------------
  // address widths
  // --------------------
  // word address is tag over index
  localparam int icache_tag_width_lp  = 12;
  localparam int icache_addr_width_lp = 8;
  localparam int pc_width_lp          = icache_tag_width_lp + icache_addr_width_lp;

  localparam int instr_width_lp = 32;

  // --------------------
  // rv32 immediates
  // --------------------
  localparam int bimm_width_lp     = 12;
  localparam int jimm_width_lp     = 20;
  // byte immediates carry an implicit zero lsb
  localparam int bimm_low_width_lp = bimm_width_lp + 1;
  localparam int jimm_low_width_lp = jimm_width_lp + 1;

  // byte pc bits above the pre-computed low part
  localparam int branch_high_width_lp = pc_width_lp + 2 - bimm_low_width_lp;
  localparam int jal_high_width_lp    = pc_width_lp + 2 - jimm_low_width_lp;

  localparam logic [6:0] opcode_branch_lp = 7'b1100011;
  localparam logic [6:0] opcode_jal_lp    = 7'b1101111;

  // --------------------
  // structs
  // --------------------
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] op;
  } rv32_instr_s;

  // one cache line, a single instruction word
  typedef struct packed {
    logic                           lower_sign;
    logic                           lower_cout;
    logic [icache_tag_width_lp-1:0] tag;
    rv32_instr_s                    instr;
  } icache_entry_s;

  // b-type immediate as a 13 bit byte offset
  function automatic logic [bimm_low_width_lp-1:0] bimm_extract(rv32_instr_s instr);
    return {instr.funct7[6], instr.rd[0], instr.funct7[5:0], instr.rd[4:1], 1'b0};
  endfunction

  // j-type immediate as a 21 bit byte offset
  function automatic logic [jimm_low_width_lp-1:0] jimm_extract(rv32_instr_s instr);
    return {instr.funct7[6], instr.rs1, instr.funct3, instr.rs2[0],
            instr.funct7[5:0], instr.rs2[4:1], 1'b0};
  endfunction

endpackage
